// File: common/dram_phy_pkg.sv
//////////////////////////////
// dram phy shared widths, pin bundles
// and idle values for the retiming paths
//////////////////////////////
`default_nettype none

package dram_phy_pkg;

    // data pins per half word
    localparam int dq_width = 16;
    localparam int addr_width = 13;
    localparam int bank_width = 2;
    // ranks set chip select and cke width
    localparam int rank_count = 2;
    // one strobe and one mask per byte lane
    localparam int dqs_width = 2;
    localparam int dqm_width = 2;

    // command pins, active low controls
    typedef struct packed {
        logic [rank_count-1:0] s_n;
        logic                  ras_n;
        logic                  cas_n;
        logic                  we_n;
        logic [bank_width-1:0] ba;
        logic [addr_width-1:0] a;
    } cmd_t;

    // write word at clock rate, high half first
    typedef struct packed {
        logic [dq_width-1:0]  dq_high;
        logic [dq_width-1:0]  dq_low;
        logic [dqm_width-1:0] dqm_high;
        logic [dqm_width-1:0] dqm_low;
        logic                 dqoe;
    } wr_word_t;

    // nop with both ranks deselected
    localparam cmd_t cmd_idle = '{
        s_n:   {rank_count{1'b1}},
        ras_n: 1'b1,
        cas_n: 1'b1,
        we_n:  1'b1,
        ba:    '0,
        a:     '0
    };

    // bus released, nothing masked
    localparam wr_word_t wr_idle = '0;

endpackage

`default_nettype wire

// File: hdl/phy_retime_stage.sv
//////////////////////////////
// two-stage hold then drive register
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module phy_retime_stage
#(
    parameter type      payload_t   = logic [7:0],
    parameter payload_t reset_value = '0
)
(
    input  logic     int_drm_clock_buffered,
    input  logic     system_reset_in,
    input  payload_t d,
    output payload_t q
);

    payload_t hold_q;
    payload_t drive_q;

    // first stage, captures the next value
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            hold_q <= reset_value;
        end
        else
        begin
            hold_q <= d;
        end
    end

    // second stage takes the place of the old 90 degree drive flop
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            drive_q <= reset_value;
        end
        else
        begin
            drive_q <= hold_q;
        end
    end

    assign q = drive_q;

endmodule

`default_nettype wire

// File: dram_phy/dram_cmd_path.sv
//////////////////////////////
// dram command retiming and
// per rank clock enable registers
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dram_cmd_path
    import dram_phy_pkg::*;
(
    input  logic                  int_drm_clock_buffered,
    input  logic                  system_reset_in,

    input  cmd_t                  next_cmd,
    input  logic                  next_cke,

    output logic [rank_count-1:0] s_n,
    output logic                  ras_n,
    output logic                  cas_n,
    output logic                  we_n,
    output logic [bank_width-1:0] ba,
    output logic [addr_width-1:0] a,
    output logic [rank_count-1:0] cke
);

    cmd_t cmd_q;

    // command goes out two cycles after sampling
    phy_retime_stage
    #(
        .payload_t   (cmd_t),
        .reset_value (cmd_idle)
    )
    u_cmd_stage
    (
        .int_drm_clock_buffered (int_drm_clock_buffered),
        .system_reset_in        (system_reset_in),
        .d                      (next_cmd),
        .q                      (cmd_q)
    );

    // split into the pins
    assign s_n   = cmd_q.s_n;
    assign ras_n = cmd_q.ras_n;
    assign cas_n = cmd_q.cas_n;
    assign we_n  = cmd_q.we_n;
    assign ba    = cmd_q.ba;
    assign a     = cmd_q.a;

    // one flop per rank so each can sit next to its own pin.
    // cke is slow, a single stage is enough
    for (genvar rank = 0; rank < rank_count; rank++)
    begin : g_cke
        logic cke_q;

        always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
        begin
            if (system_reset_in)
            begin
                cke_q <= 1'b0;
            end
            else
            begin
                cke_q <= next_cke;
            end
        end

        assign cke[rank] = cke_q;
    end

endmodule

`default_nettype wire

// File: dram_phy/dram_data_path.sv
//////////////////////////////
// write word staging, dqs strobe
// registers and read data capture
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dram_data_path
    import dram_phy_pkg::*;
(
    input  logic                 int_drm_clock_buffered,
    input  logic                 system_reset_in,

    // write side from the controller
    input  wr_word_t             next_wr,
    input  logic [dqs_width-1:0] next_dqs_high,
    input  logic [dqs_width-1:0] next_dqs_low,

    // read halves from the pads
    input  logic [dq_width-1:0]  input_dq_high,
    input  logic [dq_width-1:0]  input_dq_low,

    output logic [dq_width-1:0]  dq_high,
    output logic [dq_width-1:0]  dq_low,
    output logic [dqm_width-1:0] dqm_high,
    output logic [dqm_width-1:0] dqm_low,
    output logic                 dq_oe,

    output logic [dqs_width-1:0] dqs_high,
    output logic [dqs_width-1:0] dqs_low,
    output logic                 dqs_oe,

    output logic [dq_width-1:0]  read_dq_high,
    output logic [dq_width-1:0]  read_dq_low
);

    wr_word_t wr_q;

    // data, masks and oe share the two-stage path
    phy_retime_stage
    #(
        .payload_t   (wr_word_t),
        .reset_value (wr_idle)
    )
    u_wr_stage
    (
        .int_drm_clock_buffered (int_drm_clock_buffered),
        .system_reset_in        (system_reset_in),
        .d                      (next_wr),
        .q                      (wr_q)
    );

    assign dq_high  = wr_q.dq_high;
    assign dq_low   = wr_q.dq_low;
    assign dqm_high = wr_q.dqm_high;
    assign dqm_low  = wr_q.dqm_low;
    assign dq_oe    = wr_q.dqoe;

    // strobes run one cycle ahead of the data,
    // so dqs_oe leads dq_oe by a cycle
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            dqs_high <= '0;
            dqs_low  <= '0;
            dqs_oe   <= 1'b0;
        end
        else
        begin
            dqs_high <= next_dqs_high;
            dqs_low  <= next_dqs_low;
            dqs_oe   <= next_wr.dqoe;
        end
    end

    // read capture
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            read_dq_high <= '0;
            read_dq_low  <= '0;
        end
        else
        begin
            read_dq_high <= input_dq_high;
            read_dq_low  <= input_dq_low;
        end
    end

endmodule

`default_nettype wire

// File: hdl/dram_phy_top.sv
//////////////////////////////
// dram phy retiming top level
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dram_phy_top
    import dram_phy_pkg::*;
(
    input  logic                  int_drm_clock_buffered,
    input  logic                  system_reset_in,

    // controller side
    input  cmd_t                  next_cmd,
    input  logic                  next_cke,
    input  wr_word_t              next_wr,
    input  logic [dqs_width-1:0]  next_dqs_high,
    input  logic [dqs_width-1:0]  next_dqs_low,
    input  logic [dq_width-1:0]   input_dq_high,
    input  logic [dq_width-1:0]   input_dq_low,

    // command pins
    output logic [rank_count-1:0] s_n,
    output logic                  ras_n,
    output logic                  cas_n,
    output logic                  we_n,
    output logic [bank_width-1:0] ba,
    output logic [addr_width-1:0] a,
    output logic [rank_count-1:0] cke,

    // data and strobe pins
    output logic [dq_width-1:0]   dq_high,
    output logic [dq_width-1:0]   dq_low,
    output logic [dqm_width-1:0]  dqm_high,
    output logic [dqm_width-1:0]  dqm_low,
    output logic                  dq_oe,
    output logic [dqs_width-1:0]  dqs_high,
    output logic [dqs_width-1:0]  dqs_low,
    output logic                  dqs_oe,
    output logic [dq_width-1:0]   read_dq_high,
    output logic [dq_width-1:0]   read_dq_low
);

    dram_cmd_path u_dram_cmd_path
    (
        .int_drm_clock_buffered (int_drm_clock_buffered),
        .system_reset_in        (system_reset_in),
        .next_cmd               (next_cmd),
        .next_cke               (next_cke),
        .s_n                    (s_n),
        .ras_n                  (ras_n),
        .cas_n                  (cas_n),
        .we_n                   (we_n),
        .ba                     (ba),
        .a                      (a),
        .cke                    (cke)
    );

    // all data staging on the same clock as the command path
    dram_data_path u_dram_data_path
    (
        .int_drm_clock_buffered (int_drm_clock_buffered),
        .system_reset_in        (system_reset_in),
        .next_wr                (next_wr),
        .next_dqs_high          (next_dqs_high),
        .next_dqs_low           (next_dqs_low),
        .input_dq_high          (input_dq_high),
        .input_dq_low           (input_dq_low),
        .dq_high                (dq_high),
        .dq_low                 (dq_low),
        .dqm_high               (dqm_high),
        .dqm_low                (dqm_low),
        .dq_oe                  (dq_oe),
        .dqs_high               (dqs_high),
        .dqs_low                (dqs_low),
        .dqs_oe                 (dqs_oe),
        .read_dq_high           (read_dq_high),
        .read_dq_low            (read_dq_low)
    );

endmodule

`default_nettype wire

// File: test/dram_phy_sva.sv
//////////////////////////////
// reset and output enable
// assertions for the dram phy
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module dram_phy_sva
    import dram_phy_pkg::*;
(
    input logic                  int_drm_clock_buffered,
    input logic                  system_reset_in,
    input logic [rank_count-1:0] s_n,
    input logic                  ras_n,
    input logic                  cas_n,
    input logic                  we_n,
    input logic [bank_width-1:0] ba,
    input logic [addr_width-1:0] a,
    input logic [rank_count-1:0] cke,
    input logic [dq_width-1:0]   dq_high,
    input logic [dq_width-1:0]   dq_low,
    input logic [dqm_width-1:0]  dqm_high,
    input logic [dqm_width-1:0]  dqm_low,
    input logic                  dq_oe,
    input logic [dqs_width-1:0]  dqs_high,
    input logic [dqs_width-1:0]  dqs_low,
    input logic                  dqs_oe,
    input logic [dq_width-1:0]   read_dq_high,
    input logic [dq_width-1:0]   read_dq_low
);

    // command pins park on the idle command
    reset_cmd_idle: assert property (@(posedge int_drm_clock_buffered)
        system_reset_in |-> ({s_n, ras_n, cas_n, we_n, ba, a} == cmd_idle))
        else $error("command pins not idle while reset is high");

    reset_data_idle: assert property (@(posedge int_drm_clock_buffered)
        system_reset_in |-> (cke == '0 && dq_oe == 1'b0 && dqs_oe == 1'b0
            && dq_high == '0 && dq_low == '0 && dqm_high == '0 && dqm_low == '0
            && dqs_high == '0 && dqs_low == '0
            && read_dq_high == '0 && read_dq_low == '0))
        else $error("data side outputs not idle while reset is high");

    // strobe enable leads the data enable by one cycle
    oe_follows_dqs: assert property (@(posedge int_drm_clock_buffered)
        disable iff (system_reset_in) dq_oe == $past(dqs_oe))
        else $error("dq_oe does not follow dqs_oe of the previous cycle");

endmodule

bind dram_phy_top dram_phy_sva u_dram_phy_sva
(
    .int_drm_clock_buffered (int_drm_clock_buffered),
    .system_reset_in        (system_reset_in),
    .s_n                    (s_n),
    .ras_n                  (ras_n),
    .cas_n                  (cas_n),
    .we_n                   (we_n),
    .ba                     (ba),
    .a                      (a),
    .cke                    (cke),
    .dq_high                (dq_high),
    .dq_low                 (dq_low),
    .dqm_high               (dqm_high),
    .dqm_low                (dqm_low),
    .dq_oe                  (dq_oe),
    .dqs_high               (dqs_high),
    .dqs_low                (dqs_low),
    .dqs_oe                 (dqs_oe),
    .read_dq_high           (read_dq_high),
    .read_dq_low            (read_dq_low)
);

`default_nettype wire

// File: test/tb_dram_phy.sv
//////////////////////////////
// dram phy testbench, random traffic
// checked against a latency model
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_dram_phy
    import dram_phy_pkg::*;
;

    localparam int clk_period      = 20;
    localparam int drive_delay     = 1;
    localparam int reset_cycles    = 2;
    localparam int random_cycles   = 600;
    localparam int mid_reset_cycle = 300;
    localparam int watchdog_cycles = reset_cycles + random_cycles + 10;

    // outputs with one cycle of latency, grouped for comparison
    typedef struct packed {
        logic [rank_count-1:0] cke;
        logic [dqs_width-1:0]  dqs_high;
        logic [dqs_width-1:0]  dqs_low;
        logic                  dqs_oe;
        logic [dq_width-1:0]   read_dq_high;
        logic [dq_width-1:0]   read_dq_low;
    } fast_group_t;

    logic                  int_drm_clock_buffered;
    logic                  system_reset_in;
    cmd_t                  next_cmd;
    logic                  next_cke;
    wr_word_t              next_wr;
    logic [dqs_width-1:0]  next_dqs_high;
    logic [dqs_width-1:0]  next_dqs_low;
    logic [dq_width-1:0]   input_dq_high;
    logic [dq_width-1:0]   input_dq_low;

    logic [rank_count-1:0] s_n;
    logic                  ras_n;
    logic                  cas_n;
    logic                  we_n;
    logic [bank_width-1:0] ba;
    logic [addr_width-1:0] a;
    logic [rank_count-1:0] cke;
    logic [dq_width-1:0]   dq_high;
    logic [dq_width-1:0]   dq_low;
    logic [dqm_width-1:0]  dqm_high;
    logic [dqm_width-1:0]  dqm_low;
    logic                  dq_oe;
    logic [dqs_width-1:0]  dqs_high;
    logic [dqs_width-1:0]  dqs_low;
    logic                  dqs_oe;
    logic [dq_width-1:0]   read_dq_high;
    logic [dq_width-1:0]   read_dq_low;

    int seed;
    int burst_left;
    int checks_done = 0;

    // input histories, index 0 is the newest sample
    int                   sample_depth = 0;
    cmd_t                 cmd_hist [2];
    wr_word_t             wr_hist [2];
    logic                 cke_hist;
    logic [dqs_width-1:0] dqs_high_hist;
    logic [dqs_width-1:0] dqs_low_hist;
    logic [dq_width-1:0]  rd_high_hist;
    logic [dq_width-1:0]  rd_low_hist;

    dram_phy_top u_dram_phy_top
    (
        .int_drm_clock_buffered (int_drm_clock_buffered),
        .system_reset_in        (system_reset_in),
        .next_cmd               (next_cmd),
        .next_cke               (next_cke),
        .next_wr                (next_wr),
        .next_dqs_high          (next_dqs_high),
        .next_dqs_low           (next_dqs_low),
        .input_dq_high          (input_dq_high),
        .input_dq_low           (input_dq_low),
        .s_n                    (s_n),
        .ras_n                  (ras_n),
        .cas_n                  (cas_n),
        .we_n                   (we_n),
        .ba                     (ba),
        .a                      (a),
        .cke                    (cke),
        .dq_high                (dq_high),
        .dq_low                 (dq_low),
        .dqm_high               (dqm_high),
        .dqm_low                (dqm_low),
        .dq_oe                  (dq_oe),
        .dqs_high               (dqs_high),
        .dqs_low                (dqs_low),
        .dqs_oe                 (dqs_oe),
        .read_dq_high           (read_dq_high),
        .read_dq_low            (read_dq_low)
    );

    always #(clk_period / 2) int_drm_clock_buffered = ~int_drm_clock_buffered;

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string signal_name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("FAIL %s at %0d ns: got 0x%0h, expected 0x%0h",
                 signal_name, $time, got, expected);
        stop_run("an output did not match the latency model");
    endtask

    task automatic check_cmd(input cmd_t got, input cmd_t expected);
        checks_done++;
        if (got.s_n !== expected.s_n)
            report_mismatch("s_n", 32'(got.s_n), 32'(expected.s_n));
        if (got.ras_n !== expected.ras_n)
            report_mismatch("ras_n", 32'(got.ras_n), 32'(expected.ras_n));
        if (got.cas_n !== expected.cas_n)
            report_mismatch("cas_n", 32'(got.cas_n), 32'(expected.cas_n));
        if (got.we_n !== expected.we_n)
            report_mismatch("we_n", 32'(got.we_n), 32'(expected.we_n));
        if (got.ba !== expected.ba)
            report_mismatch("ba", 32'(got.ba), 32'(expected.ba));
        if (got.a !== expected.a)
            report_mismatch("a", 32'(got.a), 32'(expected.a));
    endtask

    task automatic check_wr(input wr_word_t got, input wr_word_t expected);
        checks_done++;
        if (got.dq_high !== expected.dq_high)
            report_mismatch("dq_high", 32'(got.dq_high), 32'(expected.dq_high));
        if (got.dq_low !== expected.dq_low)
            report_mismatch("dq_low", 32'(got.dq_low), 32'(expected.dq_low));
        if (got.dqm_high !== expected.dqm_high)
            report_mismatch("dqm_high", 32'(got.dqm_high), 32'(expected.dqm_high));
        if (got.dqm_low !== expected.dqm_low)
            report_mismatch("dqm_low", 32'(got.dqm_low), 32'(expected.dqm_low));
        if (got.dqoe !== expected.dqoe)
            report_mismatch("dq_oe", 32'(got.dqoe), 32'(expected.dqoe));
    endtask

    task automatic check_fast(input fast_group_t got, input fast_group_t expected);
        checks_done++;
        if (got.cke !== expected.cke)
            report_mismatch("cke", 32'(got.cke), 32'(expected.cke));
        if (got.dqs_high !== expected.dqs_high)
            report_mismatch("dqs_high", 32'(got.dqs_high), 32'(expected.dqs_high));
        if (got.dqs_low !== expected.dqs_low)
            report_mismatch("dqs_low", 32'(got.dqs_low), 32'(expected.dqs_low));
        if (got.dqs_oe !== expected.dqs_oe)
            report_mismatch("dqs_oe", 32'(got.dqs_oe), 32'(expected.dqs_oe));
        if (got.read_dq_high !== expected.read_dq_high)
            report_mismatch("read_dq_high", 32'(got.read_dq_high), 32'(expected.read_dq_high));
        if (got.read_dq_low !== expected.read_dq_low)
            report_mismatch("read_dq_low", 32'(got.read_dq_low), 32'(expected.read_dq_low));
    endtask

    // two cycle paths need two samples since reset, one cycle paths need one
    function automatic void predict_outputs(output cmd_t exp_cmd, output wr_word_t exp_wr,
                                            output fast_group_t exp_fast);
        exp_cmd  = (sample_depth >= 2) ? cmd_hist[1] : cmd_idle;
        exp_wr   = (sample_depth >= 2) ? wr_hist[1] : wr_idle;
        exp_fast = '0;
        if (sample_depth >= 1)
        begin
            exp_fast.cke          = {rank_count{cke_hist}};
            exp_fast.dqs_high     = dqs_high_hist;
            exp_fast.dqs_low      = dqs_low_hist;
            exp_fast.dqs_oe       = wr_hist[0].dqoe;
            exp_fast.read_dq_high = rd_high_hist;
            exp_fast.read_dq_low  = rd_low_hist;
        end
    endfunction

    // record what the DUT samples on each edge
    always @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            sample_depth <= 0;
        end
        else
        begin
            if (sample_depth < 2)
                sample_depth <= sample_depth + 1;
            cmd_hist[1]   <= cmd_hist[0];
            cmd_hist[0]   <= next_cmd;
            wr_hist[1]    <= wr_hist[0];
            wr_hist[0]    <= next_wr;
            cke_hist      <= next_cke;
            dqs_high_hist <= next_dqs_high;
            dqs_low_hist  <= next_dqs_low;
            rd_high_hist  <= input_dq_high;
            rd_low_hist   <= input_dq_low;
        end
    end

    // outputs are settled mid cycle
    always @(negedge int_drm_clock_buffered)
    begin : compare_outputs
        cmd_t        got_cmd;
        cmd_t        exp_cmd;
        wr_word_t    got_wr;
        wr_word_t    exp_wr;
        fast_group_t got_fast;
        fast_group_t exp_fast;

        predict_outputs(exp_cmd, exp_wr, exp_fast);
        got_cmd  = {s_n, ras_n, cas_n, we_n, ba, a};
        got_wr   = {dq_high, dq_low, dqm_high, dqm_low, dq_oe};
        got_fast = {cke, dqs_high, dqs_low, dqs_oe, read_dq_high, read_dq_low};
        check_cmd(got_cmd, exp_cmd);
        check_wr(got_wr, exp_wr);
        check_fast(got_fast, exp_fast);
    end

    task automatic drive_random_inputs();
        logic [31:0] r;
        logic [31:0] r2;

        r = $random(seed);
        next_cmd = r[$bits(cmd_t)-1:0];
        next_cke = r[31];
        r = $random(seed);
        r2 = $random(seed);
        next_wr = {r[4:0], r2};
        // dq_oe comes in bursts of back-to-back words
        r = $random(seed);
        if (burst_left == 0 && r[2:0] == 3'b000)
            burst_left = 2 + int'(r[5:3]);
        next_wr.dqoe = (burst_left != 0);
        if (burst_left != 0)
            burst_left = burst_left - 1;
        next_dqs_high = r[dqs_width+7:8];
        next_dqs_low  = r[dqs_width+11:12];
        r = $random(seed);
        input_dq_high = r[2*dq_width-1:dq_width];
        input_dq_low  = r[dq_width-1:0];
    endtask

    initial
    begin
        seed = 83562;
        burst_left = 0;
        int_drm_clock_buffered = 1'b0;
        system_reset_in = 1'b1;
        next_cmd = cmd_idle;
        next_cke = 1'b0;
        next_wr = wr_idle;
        next_dqs_high = '0;
        next_dqs_low = '0;
        input_dq_high = '0;
        input_dq_low = '0;

        repeat (reset_cycles) @(posedge int_drm_clock_buffered);
        #(drive_delay);
        system_reset_in = 1'b0;

        for (int cycle = 0; cycle < random_cycles; cycle++)
        begin
            drive_random_inputs();
            // reset in the middle of traffic
            if (cycle == mid_reset_cycle)
                system_reset_in = 1'b1;
            if (cycle == mid_reset_cycle + reset_cycles)
                system_reset_in = 1'b0;
            @(posedge int_drm_clock_buffered);
            #(drive_delay);
        end

        repeat (3) @(posedge int_drm_clock_buffered);
        #(drive_delay);
        if (checks_done > 0)
        begin
            $display("Everything OK");
            $finish;
        end
        else
        begin
            stop_run("the run ended without any completed comparison");
        end
    end

    initial
    begin : watchdog
        #(watchdog_cycles * clk_period);
        stop_run("timeout, the run did not reach its end in time");
    end

endmodule

`default_nettype wire

// File: verilog.f
common/dram_phy_pkg.sv
hdl/phy_retime_stage.sv
dram_phy/dram_cmd_path.sv
dram_phy/dram_data_path.sv
hdl/dram_phy_top.sv
test/dram_phy_sva.sv
test/tb_dram_phy.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dram phy testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_dram_phy \
    -f verilog.f

# the simulator may stop with an error status, the log decides
./obj_dir/Vtb_dram_phy > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
